// ==== logic/intc_src_pkg.sv ====
//////////////////////////////
// Interrupt source definitions for the uPD7800 interrupt controller.
// Source indices, the per-source bit struct, vector bytes and the
// constants of the input sampler. Pull in with a wildcard import.
//////////////////////////////
`default_nettype none

package intc_src_pkg;

  // Lower index wins arbitration
  typedef enum logic [2:0] {
    INT0 = 3'd0,
    INTT = 3'd1,
    INT1 = 3'd2,
    INT2 = 3'd3,
    INTS = 3'd4
  } int_src_e;

  // Bit position matches the source index
  typedef struct packed {
    logic ints;
    logic int2;
    logic int1;
    logic intt;
    logic int0;
  } int_bits_t;

  localparam int NUM_SRC = 5;

  // Vector bytes handed to the CPU on a grant
  localparam logic [7:0] VEC_INT0  = 8'h04;
  localparam logic [7:0] VEC_INTT  = 8'h08;
  localparam logic [7:0] VEC_INT1  = 8'h10;
  localparam logic [7:0] VEC_INT2  = 8'h20;
  localparam logic [7:0] VEC_INTS  = 8'h40;
  localparam logic [7:0] VEC_SOFTI = 8'h60;

  // Sample tick and edge filter
  localparam int TICK_DIV   = 12;
  localparam int TICK_W     = $clog2(TICK_DIV);
  localparam int FILTER_LEN = 4;
  // One low sample followed by three high ones, oldest in the MSB
  localparam logic [FILTER_LEN-1:0] FILTER_EDGE = {1'b0, {(FILTER_LEN-1){1'b1}}};

endpackage

`default_nettype wire

// ==== logic/intc_cmd_pkg.sv ====
//////////////////////////////
// CPU-side command definitions for the interrupt controller.
// Opcodes, the command word and the IE/MK control state.
//////////////////////////////
`default_nettype none

package intc_cmd_pkg;

  import intc_src_pkg::*;

  // One opcode per cycle, CMD_NONE when idle
  typedef enum logic [2:0] {
    CMD_NONE     = 3'd0,
    CMD_WRITE_MK = 3'd1,
    CMD_READ_MK  = 3'd2,
    CMD_EI       = 3'd3,
    CMD_DI       = 3'd4,
    CMD_SKIT     = 3'd5
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e    op;
    logic [7:0] data;
    int_src_e   idx;
  } cmd_t;

  // mk[4:0] masks a source when set, mk[5] picks INT2 polarity
  typedef struct packed {
    logic       ie;
    logic [7:0] mk;
  } ctrl_t;

  localparam logic [7:0] MK_RESET   = 8'hff;
  localparam int         MK_POL_BIT = 5;

endpackage

`default_nettype wire

// ==== logic/int_sampler.sv ====
//////////////////////////////
// Input side of the interrupt controller.
// Divides CLK by 12 for the sample tick, filters INT1/INT2 and
// turns all five lines into per-cycle set pulses.
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module int_sampler
  import intc_src_pkg::*;
  import intc_cmd_pkg::*;
(
  input  wire logic      CLK,
  input  wire logic      rst_n,
  input  wire int_bits_t raw_lines,
  input  wire ctrl_t     ctrl,
  output int_bits_t      set_pulse
);

  logic [TICK_W-1:0]          tick_cnt;
  logic                       tick;
  // Index 0 is INT1, index 1 is INT2
  logic [1:0]                 filt_line;
  logic [1:0][FILTER_LEN-1:0] hist;
  logic [1:0]                 filt_edge;

  //////////////////////////////
  // Sample tick

  assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // Edge filters

  // INT2 inverted unless rising edge is selected
  assign filt_line[0] = raw_lines.int1;
  assign filt_line[1] = raw_lines.int2 ^ ~ctrl.mk[MK_POL_BIT];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      hist <= '0;
    end else if (tick) begin
      for (int i = 0; i < 2; i++) begin
        hist[i] <= {hist[i][FILTER_LEN-2:0], filt_line[i]};
      end
    end
  end

  // Compare the history as it stood before this tick's shift
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      filt_edge[i] = tick && (hist[i] == FILTER_EDGE);
    end
  end

  // INT0 level and the timer/serial pulses go straight to pending
  always_comb begin
    set_pulse.int0 = raw_lines.int0;
    set_pulse.intt = raw_lines.intt;
    set_pulse.int1 = filt_edge[0];
    set_pulse.int2 = filt_edge[1];
    set_pulse.ints = raw_lines.ints;
  end

endmodule

`default_nettype wire

// ==== logic/int_command.sv ====
//////////////////////////////
// CPU command decoder of the interrupt controller.
// Holds IE and MK and raises the read-back and SKIT strobes
// in the same cycle as the command.
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module int_command
  import intc_src_pkg::*;
  import intc_cmd_pkg::*;
(
  input  wire logic CLK,
  input  wire logic rst_n,
  input  wire cmd_t cmd,
  input  wire logic taken,
  output ctrl_t      ctrl,
  output logic       skit_req,
  output int_src_e   skit_idx,
  output logic       rd_req,
  output logic [7:0] rd_mk
);

  //////////////////////////////
  // IE and MK

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.ie <= 1'b0;
      ctrl.mk <= MK_RESET;
    end else begin
      case (cmd.op)
        CMD_WRITE_MK: begin
          ctrl.mk <= cmd.data;
        end
        CMD_EI: begin
          ctrl.ie <= 1'b1;
        end
        CMD_DI: begin
          ctrl.ie <= 1'b0;
        end
        default: begin
        end
      endcase
      // Accepting an interrupt disables further ones
      if (taken) begin
        ctrl.ie <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Request strobes

  assign skit_req = (cmd.op == CMD_SKIT);
  assign skit_idx = cmd.idx;

  // MK as it stands before any later write
  assign rd_req = (cmd.op == CMD_READ_MK);
  assign rd_mk  = ctrl.mk;

endmodule

`default_nettype wire

// ==== logic/int_pending.sv ====
//////////////////////////////
// Request processing of the interrupt controller.
// Pending flags, the snapshot taken at opcode fetch, the
// fixed-priority grant and the SKIT test with its clearing.
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module int_pending
  import intc_src_pkg::*;
  import intc_cmd_pkg::*;
(
  input  wire logic      CLK,
  input  wire logic      rst_n,
  input  wire int_bits_t set_pulse,
  input  wire logic      int0_level,
  input  wire ctrl_t     ctrl,
  input  wire logic      fetch_start,
  input  wire logic      int_ack,
  input  wire logic      skit_req,
  input  wire int_src_e  skit_idx,
  output int_bits_t      granted,
  output logic           taken,
  output logic           skit_done,
  output logic           skit_hit
);

  logic [NUM_SRC-1:0] pend;
  logic [NUM_SRC-1:0] snap;
  logic [NUM_SRC-1:0] enabled;
  logic [NUM_SRC-1:0] grant_vec;
  logic [NUM_SRC-1:0] skit_sel;
  logic [NUM_SRC-1:0] clr;

  // IE on and mask bit clear
  assign enabled = {NUM_SRC{ctrl.ie}} & ~ctrl.mk[NUM_SRC-1:0];

  //////////////////////////////
  // Priority encoder

  // Isolate the lowest set bit of the snapshot
  assign grant_vec = snap & (~snap + 1'b1);
  assign granted   = int_bits_t'(grant_vec);
  assign taken     = int_ack && (|snap);

  //////////////////////////////
  // Clearing and pending flags

  always_comb begin
    skit_sel = '0;
    if (skit_req && (int'(skit_idx) < NUM_SRC)) begin
      skit_sel[skit_idx] = 1'b1;
    end
  end

  always_comb begin
    clr = skit_sel;
    if (taken) begin
      clr = clr | grant_vec;
    end
    // INT0 is level sensitive
    clr[INT0] = clr[INT0] | ~int0_level;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~clr) | set_pulse;
    end
  end

  // Snapshot of pending and enabled requests at opcode fetch
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      snap <= '0;
    end else if (taken) begin
      snap <= '0;
    end else if (fetch_start) begin
      snap <= pend & enabled;
    end
  end

  // SKIT tests the snapshot, not the live flags
  assign skit_done = skit_req;
  assign skit_hit  = |(snap & skit_sel);

endmodule

`default_nettype wire

// ==== logic/int_vector_out.sv ====
//////////////////////////////
// Output side of the interrupt controller.
// Registers irq and the vector byte, and the read-back and
// skip results as one-cycle pulses.
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module int_vector_out
  import intc_src_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       rst_n,
  input  wire int_bits_t  granted,
  input  wire logic       taken,
  input  wire logic       rd_req,
  input  wire logic [7:0] rd_mk,
  input  wire logic       skit_done,
  input  wire logic       skit_hit,
  output logic            irq,
  output logic [7:0]      vector,
  output logic            rd_valid,
  output logic [7:0]      rd_data,
  output logic            skip_valid,
  output logic            skip_taken
);

  logic [7:0] vec_next;

  // Granted is one-hot or empty
  always_comb begin
    case (1'b1)
      granted.int0: vec_next = VEC_INT0;
      granted.intt: vec_next = VEC_INTT;
      granted.int1: vec_next = VEC_INT1;
      granted.int2: vec_next = VEC_INT2;
      granted.ints: vec_next = VEC_INTS;
      default:      vec_next = VEC_SOFTI;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      irq        <= 1'b0;
      vector     <= VEC_SOFTI;
      rd_valid   <= 1'b0;
      skip_valid <= 1'b0;
    end else begin
      rd_valid   <= rd_req;
      skip_valid <= skit_done;
      // Drop the request as soon as it is acknowledged
      if (taken) begin
        irq    <= 1'b0;
        vector <= VEC_SOFTI;
      end else begin
        irq    <= |granted;
        vector <= vec_next;
      end
    end
  end

  // Result bytes only valid alongside their strobes
  always_ff @(posedge CLK) begin
    if (rd_req) begin
      rd_data <= rd_mk;
    end
    if (skit_done) begin
      skip_taken <= skit_hit;
    end
  end

endmodule

`default_nettype wire

// ==== logic/upd7800_intc.sv ====
//////////////////////////////
// Top level of the uPD7800 interrupt controller.
// Connects sampler, command decoder, pending logic and outputs.
// The CPU drives one command per cycle plus fetch and ack pulses.
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module upd7800_intc
  import intc_src_pkg::*;
  import intc_cmd_pkg::*;
(
  input  wire logic  CLK,
  input  wire logic  rst_n,
  input  wire logic  int0,
  input  wire logic  int1,
  input  wire logic  int2,
  input  wire logic  int_t,
  input  wire logic  int_s,
  input  wire logic  fetch_start,
  input  wire logic  int_ack,
  input  wire cmd_t  cmd,
  output logic       irq,
  output logic [7:0] vector,
  output logic       rd_valid,
  output logic [7:0] rd_data,
  output logic       skip_valid,
  output logic       skip_taken
);

  int_bits_t  raw_lines;
  int_bits_t  set_pulse;
  int_bits_t  granted;
  ctrl_t      ctrl;
  logic       skit_req;
  int_src_e   skit_idx;
  logic       rd_req;
  logic [7:0] rd_mk;
  logic       taken;
  logic       skit_done;
  logic       skit_hit;

  // Raw request lines in source order
  assign raw_lines = '{ints: int_s, int2: int2, int1: int1, intt: int_t, int0: int0};

  int_sampler u_sampler (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .raw_lines (raw_lines),
    .ctrl      (ctrl),
    .set_pulse (set_pulse)
  );

  int_command u_command (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .taken    (taken),
    .ctrl     (ctrl),
    .skit_req (skit_req),
    .skit_idx (skit_idx),
    .rd_req   (rd_req),
    .rd_mk    (rd_mk)
  );

  int_pending u_pending (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .set_pulse   (set_pulse),
    .int0_level  (int0),
    .ctrl        (ctrl),
    .fetch_start (fetch_start),
    .int_ack     (int_ack),
    .skit_req    (skit_req),
    .skit_idx    (skit_idx),
    .granted     (granted),
    .taken       (taken),
    .skit_done   (skit_done),
    .skit_hit    (skit_hit)
  );

  int_vector_out u_vector_out (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .granted    (granted),
    .taken      (taken),
    .rd_req     (rd_req),
    .rd_mk      (rd_mk),
    .skit_done  (skit_done),
    .skit_hit   (skit_hit),
    .irq        (irq),
    .vector     (vector),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .skip_valid (skip_valid),
    .skip_taken (skip_taken)
  );

endmodule

`default_nettype wire

// ==== bench/upd7800_intc_tb.sv ====
//////////////////////////////
// Testbench for the uPD7800 interrupt controller.
// Drives commands, fetch/ack pulses and request lines, and checks
// irq, vector, read-back and skip results against a reference model.
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module upd7800_intc_tb
  import intc_src_pkg::*;
  import intc_cmd_pkg::*;
();

  localparam int CLK_HALF   = 5;
  localparam int WAIT_LIMIT = 20;
  localparam int POLL_LIMIT = 30;

  logic       CLK;
  logic       rst_n;
  logic       int0;
  logic       int1;
  logic       int2;
  logic       int_t;
  logic       int_s;
  logic       fetch_start;
  logic       int_ack;
  cmd_t       cmd;
  logic       irq;
  logic [7:0] vector;
  logic       rd_valid;
  logic [7:0] rd_data;
  logic       skip_valid;
  logic       skip_taken;

  // Reference model state
  logic [4:0] model_pend;
  logic [4:0] model_snap;
  logic       model_ie;
  logic [7:0] model_mk;

  // Expected fetch results, bit 9 allows an idle result while polling
  logic [9:0] exp_q[$];
  logic [9:0] exp_entry;
  logic       fetch_ok;
  logic [1:0] fetch_pipe;
  string      test_name;
  int         mismatch_cnt;
  int         fail_cnt;
  int         cmp_errs;

  upd7800_intc dut (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .int_t       (int_t),
    .int_s       (int_s),
    .fetch_start (fetch_start),
    .int_ack     (int_ack),
    .cmd         (cmd),
    .irq         (irq),
    .vector      (vector),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .skip_valid  (skip_valid),
    .skip_taken  (skip_taken)
  );

  always #CLK_HALF CLK = ~CLK;

  //////////////////////////////
  // Reference model

  // Returns {irq, vector} for the given pending flags, IE and MK
  function automatic logic [8:0] expected_vector(input logic [4:0] pend,
                                                 input logic ie,
                                                 input logic [7:0] mk);
    logic [4:0] req;
    req = pend & ~mk[4:0] & {5{ie}};
    if (req[0]) return {1'b1, 8'h04};
    if (req[1]) return {1'b1, 8'h08};
    if (req[2]) return {1'b1, 8'h10};
    if (req[3]) return {1'b1, 8'h20};
    if (req[4]) return {1'b1, 8'h40};
    return {1'b0, 8'h60};
  endfunction

  //////////////////////////////
  // Stimulus helpers

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic send_cmd(input cmd_op_e code, input logic [7:0] value, input int_src_e src);
    cmd = '{op: code, data: value, idx: src};
    step();
    cmd = '{op: CMD_NONE, data: 8'h00, idx: INT0};
    case (code)
      CMD_WRITE_MK: model_mk = value;
      CMD_EI:       model_ie = 1'b1;
      CMD_DI:       model_ie = 1'b0;
      default:      ;
    endcase
  endtask

  task automatic set_int0(input logic level);
    int0 = level;
    model_pend[0] = level;
    wait_cycles(2);
  endtask

  task automatic pulse(input logic t, input logic s);
    int_t = t;
    int_s = s;
    step();
    int_t = 1'b0;
    int_s = 1'b0;
    model_pend[1] = model_pend[1] | t;
    model_pend[4] = model_pend[4] | s;
    wait_cycles(2);
  endtask

  // Leaves the caller two cycles after the fetch, with irq and vector updated
  task automatic fetch(input logic may_idle);
    model_snap = model_pend & ~model_mk[4:0] & {5{model_ie}};
    exp_q.push_back({may_idle, expected_vector(model_pend, model_ie, model_mk)});
    fetch_start = 1'b1;
    step();
    fetch_start = 1'b0;
    step();
  endtask

  task automatic ack();
    logic found;
    int_ack = 1'b1;
    step();
    int_ack = 1'b0;
    // Highest priority source in the snapshot is the one granted
    found = 1'b0;
    for (int i = 0; i < NUM_SRC; i++) begin
      if (!found && model_snap[i]) begin
        model_pend[i] = 1'b0;
        found = 1'b1;
      end
    end
    model_pend[0] = model_pend[0] | int0;
    if (found) model_ie = 1'b0;
    model_snap = '0;
    if ({irq, vector} !== {1'b0, 8'h60}) begin
      mismatch_cnt++;
      $display("MISMATCH %s ack: expected %h, actual %h", test_name, {1'b0, 8'h60},
               {irq, vector});
    end
  endtask

  task automatic read_mk();
    int cnt;
    send_cmd(CMD_READ_MK, 8'h00, INT0);
    cnt = 0;
    while (!rd_valid && cnt < WAIT_LIMIT) begin
      step();
      cnt++;
    end
    if (!rd_valid) begin
      fail_cnt++;
      $display("ERROR %s: no read-back pulse after a MK read", test_name);
    end else if (rd_data !== model_mk) begin
      mismatch_cnt++;
      $display("MISMATCH %s read_mk: expected %h, actual %h", test_name, model_mk, rd_data);
    end
  endtask

  task automatic skit(input int_src_e src);
    logic exp_hit;
    int   cnt;
    exp_hit = model_snap[src];
    send_cmd(CMD_SKIT, 8'h00, src);
    cnt = 0;
    while (!skip_valid && cnt < WAIT_LIMIT) begin
      step();
      cnt++;
    end
    if (!skip_valid) begin
      fail_cnt++;
      $display("ERROR %s: no skip result after a SKIT", test_name);
    end else if (skip_taken !== exp_hit) begin
      mismatch_cnt++;
      $display("MISMATCH %s skit: expected %h, actual %h", test_name, exp_hit, skip_taken);
    end
    model_pend[src] = (src == INT0) ? int0 : 1'b0;
  endtask

  // Fetch repeatedly until a filtered level raises irq
  task automatic poll_irq(input int_src_e src);
    int   polls;
    logic seen;
    polls = 0;
    seen  = 1'b0;
    model_pend[src] = 1'b1;
    while (!seen && polls < POLL_LIMIT) begin
      fetch(1'b1);
      seen = irq;
      polls++;
      if (!seen) wait_cycles(2);
    end
    if (!seen) begin
      fail_cnt++;
      $display("ERROR %s: held level on source %0d never raised irq", test_name, src);
    end
  endtask

  // SKIT every source to drop whatever is left pending
  task automatic clear_pending();
    for (int i = 0; i < NUM_SRC; i++) begin
      send_cmd(CMD_SKIT, 8'h00, int_src_e'(i));
    end
    wait_cycles(2);
    model_pend = {4'b0000, int0};
  endtask

  //////////////////////////////
  // Fetch result checker

  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pipe <= '0;
    end else begin
      fetch_pipe <= {fetch_pipe[0], fetch_start};
    end
  end

  // Negative edge keeps the compare away from the DUT update
  always @(negedge CLK) begin
    if (fetch_pipe[1]) begin
      if (exp_q.size() == 0) begin
        cmp_errs++;
        $display("ERROR %s: fetch result with no expected value", test_name);
      end else begin
        exp_entry = exp_q.pop_front();
        fetch_ok = ({irq, vector} === exp_entry[8:0]) ||
                   (exp_entry[9] && ({irq, vector} === {1'b0, 8'h60}));
        if (!fetch_ok) begin
          cmp_errs++;
          $display("MISMATCH %s fetch: expected %h, actual %h", test_name, exp_entry[8:0],
                   {irq, vector});
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence

  initial begin
    logic [31:0] rnd;
    void'($urandom(32'hb9f0e3b7));
    CLK          = 1'b0;
    rst_n        = 1'b0;
    int0         = 1'b0;
    int1         = 1'b0;
    int2         = 1'b0;
    int_t        = 1'b0;
    int_s        = 1'b0;
    fetch_start  = 1'b0;
    int_ack      = 1'b0;
    cmd          = '{op: CMD_NONE, data: 8'h00, idx: INT0};
    model_pend   = '0;
    model_snap   = '0;
    model_ie     = 1'b0;
    model_mk     = 8'hff;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    cmp_errs     = 0;
    test_name    = "reset";
    repeat (10) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    step();

    if ({irq, vector, rd_valid, skip_valid} !== {1'b0, 8'h60, 1'b0, 1'b0}) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h, actual %h", test_name, {1'b0, 8'h60, 2'b00},
               {irq, vector, rd_valid, skip_valid});
    end
    read_mk();

    test_name = "mask_rw";
    repeat (8) begin
      rnd = $urandom;
      send_cmd(CMD_WRITE_MK, rnd[7:0], INT0);
      read_mk();
    end
    // Rising INT2 polarity with the line low keeps INT2 quiet
    send_cmd(CMD_WRITE_MK, 8'h20, INT0);
    wait_cycles(60);
    clear_pending();

    test_name = "priority";
    send_cmd(CMD_EI, 8'h00, INT0);
    set_int0(1'b1);
    pulse(1'b1, 1'b1);
    fetch(1'b0);
    ack();
    fetch(1'b0);
    set_int0(1'b0);
    send_cmd(CMD_EI, 8'h00, INT0);
    fetch(1'b0);
    ack();
    send_cmd(CMD_EI, 8'h00, INT0);
    fetch(1'b0);
    ack();
    repeat (12) begin
      rnd = $urandom;
      send_cmd(CMD_WRITE_MK, {3'b001, rnd[4:0]}, INT0);
      send_cmd(CMD_EI, 8'h00, INT0);
      set_int0(rnd[5]);
      pulse(rnd[6], rnd[7]);
      fetch(1'b0);
      if (model_snap != '0) ack();
    end
    set_int0(1'b0);
    clear_pending();

    test_name = "int1_filter";
    send_cmd(CMD_WRITE_MK, 8'h20, INT0);
    send_cmd(CMD_EI, 8'h00, INT0);
    int1 = 1'b1;
    wait_cycles(20);
    int1 = 1'b0;
    repeat (6) begin
      fetch(1'b0);
      wait_cycles(8);
    end
    int1 = 1'b1;
    poll_irq(INT1);
    ack();
    int1 = 1'b0;
    wait_cycles(60);

    test_name = "int2_polarity";
    // Falling edge selected with the line idle high
    int2 = 1'b1;
    send_cmd(CMD_WRITE_MK, 8'h00, INT0);
    send_cmd(CMD_EI, 8'h00, INT0);
    wait_cycles(60);
    fetch(1'b0);
    int2 = 1'b0;
    poll_irq(INT2);
    ack();
    send_cmd(CMD_EI, 8'h00, INT0);
    int2 = 1'b1;
    wait_cycles(60);
    fetch(1'b0);
    int2 = 1'b0;
    send_cmd(CMD_WRITE_MK, 8'h20, INT0);
    wait_cycles(60);
    clear_pending();

    test_name = "skit";
    send_cmd(CMD_EI, 8'h00, INT0);
    pulse(1'b0, 1'b1);
    fetch(1'b0);
    // Non-pending source first, while INTS sits in the snapshot
    skit(INT1);
    skit(INTS);
    fetch(1'b0);
    skit(INTS);
    wait_cycles(4);

    $display("Done: %0d mismatches, %0d fetch errors, %0d other errors",
             mismatch_cnt, cmp_errs, fail_cnt);
    if (mismatch_cnt == 0 && cmp_errs == 0 && fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== upd7800_intc.f ====
logic/intc_src_pkg.sv
logic/intc_cmd_pkg.sv
logic/int_sampler.sv
logic/int_command.sv
logic/int_pending.sv
logic/int_vector_out.sv
logic/upd7800_intc.sv
bench/upd7800_intc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= upd7800_intc_tb
RTL_TOP   ?= upd7800_intc
FILELIST  ?= upd7800_intc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
